// File: logic/aes_sub_config.svh
`ifndef AES_SUB_CONFIG_SVH
`define AES_SUB_CONFIG_SVH

// Datapath geometry of the SubBytes instruction
`define AES_SUB_WORD_W 32          // Register operand and result width
`define AES_SUB_BYTE_W 8           // One byte lane
`define AES_SUB_LANES 4            // Byte lanes per word

// AES affine transform constants
`define AES_SBOX_AFFINE_C 8'h63    // Forward affine additive term
`define AES_SBOX_INV_AFFINE_C 8'h05 // Inverse affine additive term

`endif

// File: logic/aes_sub_pkg.sv
`include "aes_sub_config.svh"

package aes_sub_pkg;

        // Instruction level data
        typedef logic [`AES_SUB_WORD_W-1:0] word_t;     // Operand or result word
        typedef logic [`AES_SUB_BYTE_W-1:0] byte_t;     // Single byte lane

        // Lane in progress inside the controller
        typedef logic [$clog2(`AES_SUB_LANES)-1:0] lane_idx_t;

        // Controller FSM
        typedef enum logic [1:0] {
                SUB_IDLE = 2'd0,                        // Waiting for valid
                SUB_RUN  = 2'd1,                        // One lane per cycle
                SUB_DONE = 2'd2                         // Ready pulse
        } sub_state_t;

endpackage

// File: logic/gf_pkg.sv
package gf_pkg;

        // GF(2^8) in AES polynomial basis or tower basis
        typedef logic [7:0] gf8_t;

        // GF(2^4) as GF((2^2)^2) with the y coefficient in the high half
        typedef logic [3:0] gf4_t;

        // GF(2^2) over x^2 + x + 1
        typedef logic [1:0] gf2_t;

endpackage

// File: logic/gf_inverse.sv
`timescale 1ns/10ps

module gf_inverse
        import gf_pkg::*;
(
        input  gf8_t a,
        output gf8_t a_inv              // Zero maps to zero
);

        // Tower GF((2^4)^2) over x^2 + x + lambda
        localparam gf4_t LAMBDA = 4'hc;

        gf8_t a_t;                      // Operand in tower basis
        gf4_t hi;
        gf4_t lo;
        gf4_t norm;
        gf4_t norm_inv;
        gf8_t inv_t;

        function automatic gf2_t gf2_mul(input gf2_t p, input gf2_t q);
                gf2_t k;
                k[1] = (p[1] & q[1]) ^ (p[0] & q[1]) ^ (p[1] & q[0]);
                k[0] = (p[1] & q[1]) ^ (p[0] & q[0]);
                return k;
        endfunction

        // Squaring equals inversion in GF(2^2)
        function automatic gf2_t gf2_sq(input gf2_t p);
                return {p[1], p[1] ^ p[0]};
        endfunction

        function automatic gf2_t gf2_phi(input gf2_t p);
                return {p[1] ^ p[0], p[1]};     // Times phi = {10}
        endfunction

        function automatic gf4_t gf4_mul(input gf4_t p, input gf4_t q);
                gf2_t hh;
                gf2_t k_hi;
                gf2_t k_lo;
                hh   = gf2_mul(p[3:2], q[3:2]);
                k_hi = hh ^ gf2_mul(p[3:2], q[1:0]) ^ gf2_mul(p[1:0], q[3:2]);
                k_lo = gf2_phi(hh) ^ gf2_mul(p[1:0], q[1:0]);
                return {k_hi, k_lo};
        endfunction

        function automatic gf4_t gf4_sq(input gf4_t p);
                gf2_t h2;
                h2 = gf2_sq(p[3:2]);
                return {h2, gf2_phi(h2) ^ gf2_sq(p[1:0])};
        endfunction

        function automatic gf4_t gf4_sq_scale(input gf4_t p);
                return gf4_mul(gf4_sq(p), LAMBDA);
        endfunction

        function automatic gf4_t gf4_inv(input gf4_t p);
                gf2_t d;
                d = gf2_sq(gf2_phi(gf2_sq(p[3:2])) ^ gf2_mul(p[3:2], p[1:0]) ^
                           gf2_sq(p[1:0]));
                return {gf2_mul(p[3:2], d), gf2_mul(p[3:2] ^ p[1:0], d)};
        endfunction

        // Isomorphism from the AES basis into the tower basis
        function automatic gf8_t to_tower(input gf8_t q);
                gf8_t k;
                k[7] = q[7] ^ q[5];
                k[6] = q[7] ^ q[6] ^ q[4] ^ q[3] ^ q[2] ^ q[1];
                k[5] = q[7] ^ q[5] ^ q[3] ^ q[2];
                k[4] = q[7] ^ q[5] ^ q[3] ^ q[2] ^ q[1];
                k[3] = q[7] ^ q[6] ^ q[2] ^ q[1];
                k[2] = q[7] ^ q[4] ^ q[3] ^ q[2] ^ q[1];
                k[1] = q[6] ^ q[4] ^ q[1];
                k[0] = q[6] ^ q[1] ^ q[0];
                return k;
        endfunction

        function automatic gf8_t from_tower(input gf8_t q);
                gf8_t k;
                k[7] = q[7] ^ q[6] ^ q[5] ^ q[1];
                k[6] = q[6] ^ q[2];
                k[5] = q[6] ^ q[5] ^ q[1];
                k[4] = q[6] ^ q[5] ^ q[4] ^ q[2] ^ q[1];
                k[3] = q[5] ^ q[4] ^ q[3] ^ q[2] ^ q[1];
                k[2] = q[7] ^ q[4] ^ q[3] ^ q[2] ^ q[1];
                k[1] = q[5] ^ q[4];
                k[0] = q[6] ^ q[5] ^ q[4] ^ q[2] ^ q[0];
                return k;
        endfunction

        assign a_t = to_tower(a);
        assign hi  = a_t[7:4];
        assign lo  = a_t[3:0];

        // Norm is lambda*hi^2 + hi*lo + lo^2
        assign norm     = gf4_sq_scale(hi) ^ gf4_mul(hi, lo) ^ gf4_sq(lo);
        assign norm_inv = gf4_inv(norm);
        assign inv_t    = {gf4_mul(hi, norm_inv), gf4_mul(hi ^ lo, norm_inv)};
        assign a_inv    = from_tower(inv_t);

endmodule

// File: logic/aes_sbox.sv
`timescale 1ns/10ps
`include "aes_sub_config.svh"

module aes_sbox
        import gf_pkg::*;
(
        input  gf8_t sbox_in,
        input  logic inv,               // Inverse S-box when set
        output gf8_t sbox_out
);

        gf8_t field_in;
        gf8_t field_out;

        function automatic gf8_t rotl8(input gf8_t a, input int n);
                return gf8_t'((a << n) | (a >> (8 - n)));
        endfunction

        // b ^ (b<<<1) ^ (b<<<2) ^ (b<<<3) ^ (b<<<4) ^ 0x63
        function automatic gf8_t affine_fwd(input gf8_t b);
                gf8_t s;
                s = b ^ rotl8(b, 1) ^ rotl8(b, 2) ^ rotl8(b, 3) ^ rotl8(b, 4);
                return s ^ `AES_SBOX_AFFINE_C;
        endfunction

        // (s<<<1) ^ (s<<<3) ^ (s<<<6) ^ 0x05
        function automatic gf8_t affine_inv(input gf8_t s);
                gf8_t b;
                b = rotl8(s, 1) ^ rotl8(s, 3) ^ rotl8(s, 6);
                return b ^ `AES_SBOX_INV_AFFINE_C;
        endfunction

        // Inverse path applies the affine map before the field inverse
        assign field_in = inv ? affine_inv(sbox_in) : sbox_in;

        gf_inverse inverse_i (
                .a     (field_in),
                .a_inv (field_out)
        );

        // Forward path applies the affine map after the field inverse
        assign sbox_out = inv ? field_out : affine_fwd(field_out);

endmodule

// File: logic/aes_sub_ctrl.sv
`timescale 1ns/10ps
`include "aes_sub_config.svh"

module aes_sub_ctrl
        import aes_sub_pkg::*;
(
        input  logic  clock,
        input  logic  arst_n,
        input  logic  valid,
        input  word_t rs1,
        input  word_t rs2,
        input  logic  enc,
        input  logic  rot,
        output byte_t sbox_in,          // Lane under substitution
        output logic  inv,              // Inverse S-box select
        input  byte_t sbox_out,         // Same cycle S-box result
        output logic  ready,
        output word_t result
);

        sub_state_t state;
        lane_idx_t  lane;               // Lane being substituted
        lane_idx_t  dest;               // Byte slot in result
        word_t      gathered;
        word_t      data_q;             // Gathered operand bytes
        logic       enc_q;
        logic       rot_q;
        logic       accept;

        assign accept = (state == SUB_IDLE) && valid;

        // Even lanes from rs1 and odd lanes from rs2
        always_comb begin
                gathered = '0;
                for (int i = 0; i < `AES_SUB_LANES; i++) begin
                        if (i % 2 == 0) begin
                                gathered[i*`AES_SUB_BYTE_W +: `AES_SUB_BYTE_W] =
                                        rs1[i*`AES_SUB_BYTE_W +: `AES_SUB_BYTE_W];
                        end else begin
                                gathered[i*`AES_SUB_BYTE_W +: `AES_SUB_BYTE_W] =
                                        rs2[i*`AES_SUB_BYTE_W +: `AES_SUB_BYTE_W];
                        end
                end
        end

        // Rotation moves every lane up one slot and wraps lane 3 to slot 0
        assign dest    = lane + lane_idx_t'(rot_q);
        assign sbox_in = data_q[lane*`AES_SUB_BYTE_W +: `AES_SUB_BYTE_W];
        assign inv     = ~enc_q;
        assign ready   = (state == SUB_DONE);

        always_ff @(posedge clock) begin
                if (accept) begin
                        data_q <= gathered;
                        enc_q  <= enc;
                        rot_q  <= rot;
                end
        end

        always_ff @(posedge clock or negedge arst_n) begin
                if (!arst_n) begin
                        state  <= SUB_IDLE;
                        lane   <= '0;
                        result <= '0;
                end else begin
                        case (state)
                                SUB_IDLE: begin
                                        if (accept) begin
                                                state <= SUB_RUN;
                                                lane  <= '0;
                                        end
                                end
                                SUB_RUN: begin
                                        result[dest*`AES_SUB_BYTE_W +: `AES_SUB_BYTE_W] <=
                                                sbox_out;
                                        lane <= lane + 1'b1;
                                        if (lane == lane_idx_t'(`AES_SUB_LANES - 1)) begin
                                                state <= SUB_DONE;      // Last lane written
                                        end
                                end
                                SUB_DONE: begin
                                        state <= SUB_IDLE;
                                end
                                default: begin
                                        state <= SUB_IDLE;
                                end
                        endcase
                end
        end

endmodule

// File: logic/aes_sub_unit.sv
`timescale 1ns/10ps

module aes_sub_unit
        import aes_sub_pkg::*;
(
        input  logic  clock,
        input  logic  arst_n,
        input  logic  valid,            // Operands present
        input  word_t rs1,              // Supplies lanes 0 and 2
        input  word_t rs2,              // Supplies lanes 1 and 3
        input  logic  enc,              // Forward S-box when set
        input  logic  rot,              // Rotate result left one byte
        output logic  ready,            // One cycle completion pulse
        output word_t result
);

        byte_t sbox_in;
        byte_t sbox_out;
        logic  sbox_inv;

        aes_sub_ctrl ctrl_i (
                .clock    (clock),
                .arst_n   (arst_n),
                .valid    (valid),
                .rs1      (rs1),
                .rs2      (rs2),
                .enc      (enc),
                .rot      (rot),
                .sbox_in  (sbox_in),
                .inv      (sbox_inv),
                .sbox_out (sbox_out),
                .ready    (ready),
                .result   (result)
        );

        aes_sbox sbox_i (               // Single shared S-box
                .sbox_in  (sbox_in),
                .inv      (sbox_inv),
                .sbox_out (sbox_out)
        );

endmodule

// File: dv/aes_sub_vectors.svh
`ifndef AES_SUB_VECTORS_SVH
`define AES_SUB_VECTORS_SVH

// Row fields are rs1, rs2, enc, rot and the expected result
// Expected bytes come from the FIPS-197 S-box listing
localparam int NUM_VECTORS = 12;

word_t vec_rs1 [NUM_VECTORS];
word_t vec_rs2 [NUM_VECTORS];
logic  vec_enc [NUM_VECTORS];
logic  vec_rot [NUM_VECTORS];
word_t vec_exp [NUM_VECTORS];

task automatic set_row(input int idx, input word_t a, input word_t b,
                       input logic e, input logic r, input word_t x);
        vec_rs1[idx] = a;
        vec_rs2[idx] = b;
        vec_enc[idx] = e;
        vec_rot[idx] = r;
        vec_exp[idx] = x;
endtask

task automatic fill_vector_table();
        // 01->7c 00->63 53->ed ff->16
        set_row(0, 32'haa53bb01, 32'hffcc00dd, 1'b1, 1'b0, 32'h16ed637c);
        set_row(1, 32'haa53bb01, 32'hffcc00dd, 1'b1, 1'b1, 32'hed637c16);
        // Inverse of the row above
        set_row(2, 32'h11ed227c, 32'h16336344, 1'b0, 1'b0, 32'hff530001);
        set_row(3, 32'h11ed227c, 32'h16336344, 1'b0, 1'b1, 32'h530001ff);
        // Round 1 bytes of the FIPS-197 example
        set_row(4, 32'h5519663d, 32'he377a088, 1'b1, 1'b0, 32'h11d4e027);
        set_row(5, 32'h5519663d, 32'he377a088, 1'b1, 1'b1, 32'hd4e02711);
        set_row(6, 32'h00ae00bf, 32'h9801f102, 1'b0, 1'b0, 32'he2be2bf4);
        set_row(7, 32'h00ae00bf, 32'h9801f102, 1'b0, 1'b1, 32'hbe2bf4e2);
        // 10->ca 20->b7 30->04 40->09
        set_row(8, 32'h12203410, 32'h40563078, 1'b1, 1'b0, 32'h09b704ca);
        set_row(9, 32'h12203410, 32'h40563078, 1'b1, 1'b1, 32'hb704ca09);
        set_row(10, 32'hffb7eeca, 32'h09aa04bb, 1'b0, 1'b0, 32'h40203010);
        // bb->ea cc->4b dd->c1 ee->28
        set_row(11, 32'h01cc02bb, 32'hee03dd04, 1'b1, 1'b1, 32'h4bc1ea28);
endtask

`endif

// File: dv/tb_aes_sub.sv
`timescale 1ns/10ps
`include "aes_sub_config.svh"

module tb_aes_sub
        import aes_sub_pkg::*;
();

        localparam int RAND_TRIALS = 8;
        localparam int LATENCY     = `AES_SUB_LANES + 1;    // Accept edge through last lane
        localparam int READY_WAIT  = LATENCY + 5;

        logic  clock;
        logic  arst_n;
        logic  valid;
        word_t rs1;
        word_t rs2;
        logic  enc;
        logic  rot;
        logic  ready;
        word_t result;

        int    error_count;
        int    test_count;
        int    fail_count;
        int    cycle_count;

        `include "aes_sub_vectors.svh"

        localparam int CYCLE_LIMIT = (NUM_VECTORS + 2 * RAND_TRIALS) * 8 + 20;

        aes_sub_unit dut_i (
                .clock  (clock),
                .arst_n (arst_n),
                .valid  (valid),
                .rs1    (rs1),
                .rs2    (rs2),
                .enc    (enc),
                .rot    (rot),
                .ready  (ready),
                .result (result)
        );

        always #20 clock = ~clock;

        always @(posedge clock) begin
                cycle_count++;
                if (cycle_count >= CYCLE_LIMIT) begin
                        $display("Timeout: run exceeded %0d clock cycles", CYCLE_LIMIT);
                        $display("SIMULATION FAILED");
                        $finish;
                end
        end

        // Starts and ends 2 ns after a rising edge
        task automatic run_operation(input word_t a, input word_t b, input logic e,
                                     input logic r, output word_t res, output logic ok);
                int   edges;
                logic seen;
                ok    = 1'b1;
                seen  = 1'b0;
                edges = 0;
                rs1   = a;
                rs2   = b;
                enc   = e;
                rot   = r;
                valid = 1'b1;
                while (!seen && edges < READY_WAIT) begin
                        @(posedge clock);
                        #1;
                        edges++;
                        seen = ready;
                end
                assert (seen) else begin
                        $display("Error at %0t: ready never went high after valid", $time);
                        error_count++;
                        ok = 1'b0;
                end
                assert (!seen || edges == LATENCY) else begin
                        $display("MISMATCH at %0t: ready after %0d edges, expected %0d",
                                 $time, edges, LATENCY);
                        error_count++;
                        ok = 1'b0;
                end
                #1;
                valid = 1'b0;                           // Source drops valid on ready
                res   = result;
                @(posedge clock);
                #1;
                assert (!ready) else begin
                        $display("MISMATCH at %0t: ready held for more than one cycle", $time);
                        error_count++;
                        ok = 1'b0;
                end
                assert (result == res) else begin
                        $display("MISMATCH at %0t: result changed to %h after ready",
                                 $time, result);
                        error_count++;
                        ok = 1'b0;
                end
                #1;
        endtask

        initial begin
                word_t got;
                word_t orig;
                word_t back;
                logic  ok;
                logic  ok2;
                clock  = 1'b0;
                arst_n = 1'b0;
                valid  = 1'b0;
                rs1    = '0;
                rs2    = '0;
                enc    = 1'b0;
                rot    = 1'b0;
                orig   = $urandom(32'hf5abce6a);   // Seeds the generator
                fill_vector_table();
                repeat (2) @(posedge clock);
                #2;
                arst_n = 1'b1;
                @(posedge clock);
                #1;
                test_count++;
                assert (!ready && result == '0) else begin
                        $display("MISMATCH at %0t: after reset ready=%0b result=%h",
                                 $time, ready, result);
                        error_count++;
                        fail_count++;
                end
                $display("test %0d reset: ready=%0b result=%h", test_count, ready, result);
                #1;
                for (int i = 0; i < NUM_VECTORS; i++) begin
                        run_operation(vec_rs1[i], vec_rs2[i], vec_enc[i], vec_rot[i], got, ok);
                        assert (got == vec_exp[i]) else begin
                                $display("MISMATCH at %0t: row %0d result %h expected %h",
                                         $time, i, got, vec_exp[i]);
                                error_count++;
                                ok = 1'b0;
                        end
                        test_count++;
                        fail_count += ok ? 0 : 1;
                        $display("test %0d %s: rs1=%h rs2=%h enc=%0b rot=%0b result=%h",
                                 test_count, ok ? "ok" : "FAIL", vec_rs1[i], vec_rs2[i],
                                 vec_enc[i], vec_rot[i], got);
                end
                // Forward then inverse must restore the operand
                for (int t = 0; t < RAND_TRIALS; t++) begin
                        orig = $urandom();
                        run_operation(orig, orig, 1'b1, 1'b0, got, ok);
                        run_operation(got, got, 1'b0, 1'b0, back, ok2);
                        assert (back == orig) else begin
                                $display("MISMATCH at %0t: round trip of %h gave %h",
                                         $time, orig, back);
                                error_count++;
                                ok2 = 1'b0;
                        end
                        test_count++;
                        fail_count += (ok && ok2) ? 0 : 1;
                        $display("test %0d %s: round trip %h -> %h -> %h", test_count,
                                 (ok && ok2) ? "ok" : "FAIL", orig, got, back);
                end
                $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                         test_count, fail_count, error_count);
                if (error_count == 0) begin
                        $display("SIMULATION PASSED");
                end else begin
                        $display("SIMULATION FAILED");
                end
                $finish;
        end

endmodule

// File: src.f
+incdir+logic
+incdir+dv
logic/aes_sub_pkg.sv
logic/gf_pkg.sv
logic/gf_inverse.sv
logic/aes_sbox.sv
logic/aes_sub_ctrl.sv
logic/aes_sub_unit.sv
dv/tb_aes_sub.sv
